/* Bender.yml */
package:
  name: board_io_shell

sources:
  # RTL in compile order
  - files:
      - hw/io_shell_pkg.sv
      - hw/strap_sync.sv
      - hw/jtag_overlay_mux.sv
      - hw/usb_pinflip_mux.sv
      - hw/board_io_shell.sv

  # Testbench
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/board_io_shell_tb.sv

/* hw/board_io_shell.sv */
//////////////////////////////////////////////////////////////////////
// Board IO shell
// Routes board pads to the chip core with JTAG and USB overlays
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module board_io_shell import io_shell_pkg::*; (
  input  logic      clk_main_i,
  input  logic      arst_n_i,
  // Board side
  input  mio_vec_t  mio_pad_in_i,
  input  dio_vec_t  dio_pad_in_i,
  output mio_bus_t  mio_pad_o,
  output dio_bus_t  dio_pad_o,
  // Core side
  input  mio_bus_t  mio_core_i,
  input  dio_bus_t  dio_core_i,
  output mio_vec_t  mio_core_in_o,
  output dio_vec_t  dio_core_in_o,
  // TAP
  output jtag_req_t jtag_o,
  input  logic      jtag_tdo_i,
  // External USB transceiver
  output uphy_tx_t  uphy_tx_o,
  input  uphy_rx_t  uphy_rx_i
);

  logic jtag_en;
  logic use_uphy;

  // Between the two muxes, dedicated pins only
  dio_bus_t dio_umux;
  dio_vec_t dio_umux_in;

  //////////////////////////////////////////////////////////////////////
  // Straps
  //////////////////////////////////////////////////////////////////////

  strap_sync strap_sync_i (
    .clk_main_i       (clk_main_i),
    .arst_n_i         (arst_n_i),
    .jtag_en_strap_i  (mio_pad_in_i[MioJtagEnIdx]),
    .uphy_sel_strap_i (mio_pad_in_i[MioUphySelIdx]),
    .jtag_en_o        (jtag_en),
    .use_uphy_o       (use_uphy)
  );

  //////////////////////////////////////////////////////////////////////
  // Pad side: JTAG overlay
  //////////////////////////////////////////////////////////////////////

  jtag_overlay_mux jtag_overlay_mux_i (
    .jtag_en_i     (jtag_en),
    .mio_core_i    (mio_core_i),
    .dio_umux_i    (dio_umux),
    .mio_pad_in_i  (mio_pad_in_i),
    .dio_pad_in_i  (dio_pad_in_i),
    .jtag_tdo_i    (jtag_tdo_i),
    .mio_pad_o     (mio_pad_o),
    .dio_pad_o     (dio_pad_o),
    .mio_core_in_o (mio_core_in_o),
    .dio_umux_in_o (dio_umux_in),
    .jtag_o        (jtag_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Core side: USB pin-flip and PHY select
  //////////////////////////////////////////////////////////////////////

  usb_pinflip_mux usb_pinflip_mux_i (
    .use_uphy_i    (use_uphy),
    .dio_core_i    (dio_core_i),
    .dio_umux_in_i (dio_umux_in),
    .uphy_rx_i     (uphy_rx_i),
    .dio_umux_o    (dio_umux),
    .dio_core_in_o (dio_core_in_o),
    .uphy_tx_o     (uphy_tx_o)
  );

endmodule : board_io_shell

/* hw/io_shell_pkg.sv */
//////////////////////////////////////////////////////////////////////
// IO shell package
// Pad counts, board pin map, JTAG tie-offs and pad bus types
//////////////////////////////////////////////////////////////////////

package io_shell_pkg;

  //////////////////////////////////////////////////////////////////////
  // Pad counts and vector types
  //////////////////////////////////////////////////////////////////////

  localparam int NumMioPads = 32;
  localparam int NumDioPads = 15;

  // One bit per pad
  typedef logic [NumMioPads-1:0] mio_vec_t;
  typedef logic [NumDioPads-1:0] dio_vec_t;

  //////////////////////////////////////////////////////////////////////
  // Board pin map
  //////////////////////////////////////////////////////////////////////

  // Muxed pins, straps and JTAG resets
  localparam int MioUphySelIdx = 2;
  localparam int MioJtagEnIdx  = 16;
  localparam int MioTrstIdx    = 18;
  localparam int MioSrstIdx    = 19;

  // SPI device pins, borrowed by JTAG as TCK, TMS, TDI and TDO
  localparam int DioSckIdx = 14;
  localparam int DioCsbIdx = 13;
  localparam int DioSdiIdx = 12;
  localparam int DioSdoIdx = 11;

  // USB device pins
  localparam int DioUsbSenseIdx    = 8;
  localparam int DioUsbDpPullupIdx = 6;
  localparam int DioUsbDnPullupIdx = 5;
  localparam int DioUsbDIdx        = 2;
  localparam int DioUsbDpIdx       = 1;
  localparam int DioUsbDnIdx       = 0;

  // Core-side values on JTAG pins while JTAG owns them
  // CSB is active low, so it idles high
  localparam dio_vec_t DioJtagTieOff = dio_vec_t'(1) << DioCsbIdx;
  localparam mio_vec_t MioJtagTieOff = '0;

  //////////////////////////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////////////////////////

  // Drive toward the pads
  typedef struct packed {
    mio_vec_t out;
    mio_vec_t oe;
  } mio_bus_t;

  typedef struct packed {
    dio_vec_t out;
    dio_vec_t oe;
  } dio_bus_t;

  // Pad to TAP
  typedef struct packed {
    logic tck;
    logic tms;
    logic trst_n;
    logic srst_n;
    logic tdi;
  } jtag_req_t;

  // External USB transceiver, outputs
  typedef struct packed {
    logic dp;
    logic dn;
    logic oe_n;
    logic dppullup;
  } uphy_tx_t;

  // External USB transceiver, inputs
  typedef struct packed {
    logic dp;
    logic dn;
    logic d;
    logic sense;
  } uphy_rx_t;

endpackage : io_shell_pkg

/* hw/jtag_overlay_mux.sv */
//////////////////////////////////////////////////////////////////////
// JTAG overlay mux
// Hands the JTAG pins to the TAP and ties off the core side
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module jtag_overlay_mux import io_shell_pkg::*; (
  input  logic      jtag_en_i,
  // Core side, muxed pins go straight to the core
  input  mio_bus_t  mio_core_i,
  input  dio_bus_t  dio_umux_i,
  // Pad side
  input  mio_vec_t  mio_pad_in_i,
  input  dio_vec_t  dio_pad_in_i,
  // TAP return path
  input  logic      jtag_tdo_i,
  output mio_bus_t  mio_pad_o,
  output dio_bus_t  dio_pad_o,
  output mio_vec_t  mio_core_in_o,
  output dio_vec_t  dio_umux_in_o,
  output jtag_req_t jtag_o
);

  //////////////////////////////////////////////////////////////////////
  // Drive toward the pads
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    mio_pad_o = mio_core_i;
    dio_pad_o = dio_umux_i;

    if (jtag_en_i) begin
      // TRST and SRST become plain inputs
      mio_pad_o.out[MioTrstIdx] = 1'b0;
      mio_pad_o.oe[MioTrstIdx]  = 1'b0;
      mio_pad_o.out[MioSrstIdx] = 1'b0;
      mio_pad_o.oe[MioSrstIdx]  = 1'b0;

      // TCK, TMS and TDI in
      dio_pad_o.out[DioSckIdx] = 1'b0;
      dio_pad_o.oe[DioSckIdx]  = 1'b0;
      dio_pad_o.out[DioCsbIdx] = 1'b0;
      dio_pad_o.oe[DioCsbIdx]  = 1'b0;
      dio_pad_o.out[DioSdiIdx] = 1'b0;
      dio_pad_o.oe[DioSdiIdx]  = 1'b0;

      // TDO is the only JTAG pin we drive
      dio_pad_o.out[DioSdoIdx] = jtag_tdo_i;
      dio_pad_o.oe[DioSdoIdx]  = 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Inputs toward the core
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    mio_core_in_o = mio_pad_in_i;
    dio_umux_in_o = dio_pad_in_i;

    if (jtag_en_i) begin
      mio_core_in_o[MioTrstIdx] = MioJtagTieOff[MioTrstIdx];
      mio_core_in_o[MioSrstIdx] = MioJtagTieOff[MioSrstIdx];

      dio_umux_in_o[DioSckIdx] = DioJtagTieOff[DioSckIdx];
      dio_umux_in_o[DioCsbIdx] = DioJtagTieOff[DioCsbIdx];
      dio_umux_in_o[DioSdiIdx] = DioJtagTieOff[DioSdiIdx];
      dio_umux_in_o[DioSdoIdx] = DioJtagTieOff[DioSdoIdx];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // TAP request
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (jtag_en_i) begin
      jtag_o.tck    = dio_pad_in_i[DioSckIdx];
      jtag_o.tms    = dio_pad_in_i[DioCsbIdx];
      jtag_o.tdi    = dio_pad_in_i[DioSdiIdx];
      jtag_o.trst_n = mio_pad_in_i[MioTrstIdx];
      jtag_o.srst_n = mio_pad_in_i[MioSrstIdx];
    end else begin
      // Idle TAP: held in reset, system reset released
      jtag_o.tck    = 1'b0;
      jtag_o.tms    = 1'b0;
      jtag_o.tdi    = 1'b0;
      jtag_o.trst_n = 1'b0;
      jtag_o.srst_n = 1'b1;
    end
  end

endmodule : jtag_overlay_mux

/* hw/strap_sync.sv */
//////////////////////////////////////////////////////////////////////
// Strap synchronizer
// Brings the JTAG-enable and PHY-select board switches into clk_main
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module strap_sync (
  input  logic clk_main_i,
  input  logic arst_n_i,
  input  logic jtag_en_strap_i,
  input  logic uphy_sel_strap_i,
  output logic jtag_en_o,
  output logic use_uphy_o
);

  // Bit 1 is the JTAG strap, bit 0 the PHY strap
  logic [1:0] strap_async;
  logic [1:0] strap_meta_q;
  logic [1:0] strap_sync_q;

  assign strap_async = {jtag_en_strap_i, uphy_sel_strap_i};

  //////////////////////////////////////////////////////////////////////
  // Two flop stages
  //////////////////////////////////////////////////////////////////////

  // Both overlays stay off until the switches are sampled cleanly
  always_ff @(posedge clk_main_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      strap_meta_q <= '0;
      strap_sync_q <= '0;
    end else begin
      strap_meta_q <= strap_async;
      strap_sync_q <= strap_meta_q;
    end
  end

  assign jtag_en_o  = strap_sync_q[1];
  assign use_uphy_o = strap_sync_q[0];

endmodule : strap_sync

/* hw/usb_pinflip_mux.sv */
//////////////////////////////////////////////////////////////////////
// USB pin-flip mux
// Undoes core-side D+/D- flipping, selects the external PHY inputs
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module usb_pinflip_mux import io_shell_pkg::*; (
  input  logic     use_uphy_i,
  // Core side
  input  dio_bus_t dio_core_i,
  output dio_vec_t dio_core_in_o,
  // JTAG mux side
  input  dio_vec_t dio_umux_in_i,
  output dio_bus_t dio_umux_o,
  // External transceiver
  input  uphy_rx_t uphy_rx_i,
  output uphy_tx_t uphy_tx_o
);

  // Core drives the D- pullup only when its pins are flipped
  logic undo_swap;

  // Post-swap drive toward the pads
  dio_bus_t umux_bus;

  // Raw receive values before swapping
  logic rx_dp;
  logic rx_dn;
  logic rx_d;
  logic rx_sense;

  assign undo_swap = dio_core_i.oe[DioUsbDnPullupIdx];

  //////////////////////////////////////////////////////////////////////
  // Output direction
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    umux_bus = dio_core_i;

    if (undo_swap) begin
      // Data pair
      umux_bus.out[DioUsbDpIdx] = dio_core_i.out[DioUsbDnIdx];
      umux_bus.oe[DioUsbDpIdx]  = dio_core_i.oe[DioUsbDnIdx];
      umux_bus.out[DioUsbDnIdx] = dio_core_i.out[DioUsbDpIdx];
      umux_bus.oe[DioUsbDnIdx]  = dio_core_i.oe[DioUsbDpIdx];

      // Pullup pair
      umux_bus.out[DioUsbDpPullupIdx] = dio_core_i.out[DioUsbDnPullupIdx];
      umux_bus.oe[DioUsbDpPullupIdx]  = dio_core_i.oe[DioUsbDnPullupIdx];
      umux_bus.out[DioUsbDnPullupIdx] = dio_core_i.out[DioUsbDpPullupIdx];
      umux_bus.oe[DioUsbDnPullupIdx]  = dio_core_i.oe[DioUsbDpPullupIdx];

      // Single-ended D flips polarity, its enable does not move
      umux_bus.out[DioUsbDIdx] = ~dio_core_i.out[DioUsbDIdx];
    end
  end

  assign dio_umux_o = umux_bus;

  //////////////////////////////////////////////////////////////////////
  // Input direction
  //////////////////////////////////////////////////////////////////////

  // Pick the receive source first, then undo the flip
  always_comb begin
    if (use_uphy_i) begin
      rx_dp    = uphy_rx_i.dp;
      rx_dn    = uphy_rx_i.dn;
      rx_d     = uphy_rx_i.d;
      rx_sense = uphy_rx_i.sense;
    end else begin
      rx_dp    = dio_umux_in_i[DioUsbDpIdx];
      rx_dn    = dio_umux_in_i[DioUsbDnIdx];
      rx_d     = dio_umux_in_i[DioUsbDIdx];
      rx_sense = dio_umux_in_i[DioUsbSenseIdx];
    end
  end

  always_comb begin
    // Pullup inputs and all other pins pass straight through
    dio_core_in_o = dio_umux_in_i;

    dio_core_in_o[DioUsbDpIdx]    = undo_swap ? rx_dn : rx_dp;
    dio_core_in_o[DioUsbDnIdx]    = undo_swap ? rx_dp : rx_dn;
    dio_core_in_o[DioUsbDIdx]     = rx_d ^ undo_swap;
    // SENSE is never swapped
    dio_core_in_o[DioUsbSenseIdx] = rx_sense;
  end

  //////////////////////////////////////////////////////////////////////
  // External transceiver outputs
  //////////////////////////////////////////////////////////////////////

  // Always driven, copies what goes to the regular pads
  assign uphy_tx_o.dp   = umux_bus.out[DioUsbDpIdx];
  assign uphy_tx_o.dn   = umux_bus.out[DioUsbDnIdx];
  assign uphy_tx_o.oe_n = ~umux_bus.oe[DioUsbDpIdx];

  // Pullup only when actually enabled
  assign uphy_tx_o.dppullup = umux_bus.out[DioUsbDpPullupIdx] &
                              umux_bus.oe[DioUsbDpPullupIdx];

endmodule : usb_pinflip_mux

/* tb.f */
hw/io_shell_pkg.sv
hw/strap_sync.sv
hw/jtag_overlay_mux.sv
hw/usb_pinflip_mux.sv
hw/board_io_shell.sv
verification/tb_clk_gen.sv
verification/board_io_shell_tb.sv

/* verification/board_io_shell_tb.sv */
//////////////////////////////////////////////////////////////////////
// Board IO shell testbench
// Directed tests of pass-through, JTAG, USB flip and PHY select
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module board_io_shell_tb import io_shell_pkg::*; ();

  // All DUT outputs in one vector
  typedef struct packed {
    mio_bus_t  mio_pad;
    dio_bus_t  dio_pad;
    mio_vec_t  mio_core_in;
    dio_vec_t  dio_core_in;
    jtag_req_t jtag;
    uphy_tx_t  uphy_tx;
  } shell_out_t;

  logic      clk;
  logic      arst_n;
  mio_vec_t  mio_pad_in;
  dio_vec_t  dio_pad_in;
  mio_bus_t  mio_core;
  dio_bus_t  dio_core;
  logic      jtag_tdo;
  uphy_rx_t  uphy_rx;
  mio_bus_t  mio_pad_o;
  dio_bus_t  dio_pad_o;
  mio_vec_t  mio_core_in_o;
  dio_vec_t  dio_core_in_o;
  jtag_req_t jtag_o;
  uphy_tx_t  uphy_tx_o;
  shell_out_t dut_out;

  // Strap state the shell should reach after synchronization
  logic exp_jtag_en;
  logic exp_use_uphy;
  int   err_cnt;
  int   check_cnt;
  int   test_cnt;
  int   test_fail_cnt;

  tb_clk_gen tb_clk_gen_i (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  board_io_shell board_io_shell_i (
    .clk_main_i    (clk),
    .arst_n_i      (arst_n),
    .mio_pad_in_i  (mio_pad_in),
    .dio_pad_in_i  (dio_pad_in),
    .mio_pad_o     (mio_pad_o),
    .dio_pad_o     (dio_pad_o),
    .mio_core_i    (mio_core),
    .dio_core_i    (dio_core),
    .mio_core_in_o (mio_core_in_o),
    .dio_core_in_o (dio_core_in_o),
    .jtag_o        (jtag_o),
    .jtag_tdo_i    (jtag_tdo),
    .uphy_tx_o     (uphy_tx_o),
    .uphy_rx_i     (uphy_rx)
  );

  assign dut_out = {mio_pad_o, dio_pad_o, mio_core_in_o, dio_core_in_o, jtag_o, uphy_tx_o};

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic dio_vec_t swap_bits(input dio_vec_t v, input int a, input int b);
    dio_vec_t r;
    r    = v;
    r[a] = v[b];
    r[b] = v[a];
    return r;
  endfunction

  function automatic shell_out_t shell_model(
    input mio_vec_t pad_in_m,
    input dio_vec_t pad_in_d,
    input mio_bus_t core_m,
    input dio_bus_t core_d,
    input logic     tdo,
    input uphy_rx_t rx,
    input logic     jtag_en,
    input logic     use_uphy
  );
    shell_out_t e;
    dio_bus_t   umux;
    dio_vec_t   umux_in;
    mio_vec_t   m_mask;
    dio_vec_t   d_mask;
    logic       flip;
    logic [3:0] usb_in;
    flip   = core_d.oe[DioUsbDnPullupIdx];
    m_mask = (mio_vec_t'(1) << MioTrstIdx) | (mio_vec_t'(1) << MioSrstIdx);
    d_mask = (dio_vec_t'(1) << DioSckIdx) | (dio_vec_t'(1) << DioCsbIdx) |
             (dio_vec_t'(1) << DioSdiIdx) | (dio_vec_t'(1) << DioSdoIdx);
    // Core drive with the flip undone
    umux = core_d;
    if (flip) begin
      umux.out = swap_bits(swap_bits(core_d.out, DioUsbDpIdx, DioUsbDnIdx),
                           DioUsbDpPullupIdx, DioUsbDnPullupIdx);
      umux.oe  = swap_bits(swap_bits(core_d.oe, DioUsbDpIdx, DioUsbDnIdx),
                           DioUsbDpPullupIdx, DioUsbDnPullupIdx);
      umux.out[DioUsbDIdx] = ~core_d.out[DioUsbDIdx];
    end
    // JTAG overlay on the pad side
    e.mio_pad     = core_m;
    e.dio_pad     = umux;
    e.mio_core_in = pad_in_m;
    umux_in       = pad_in_d;
    e.jtag        = '{tck: 1'b0, tms: 1'b0, trst_n: 1'b0, srst_n: 1'b1, tdi: 1'b0};
    if (jtag_en) begin
      e.mio_pad.out  = core_m.out & ~m_mask;
      e.mio_pad.oe   = core_m.oe & ~m_mask;
      e.mio_core_in  = (pad_in_m & ~m_mask) | (MioJtagTieOff & m_mask);
      e.dio_pad.out  = (umux.out & ~d_mask) | (dio_vec_t'(tdo) << DioSdoIdx);
      e.dio_pad.oe   = (umux.oe & ~d_mask) | (dio_vec_t'(1) << DioSdoIdx);
      umux_in        = (pad_in_d & ~d_mask) | (DioJtagTieOff & d_mask);
      e.jtag.tck     = pad_in_d[DioSckIdx];
      e.jtag.tms     = pad_in_d[DioCsbIdx];
      e.jtag.tdi     = pad_in_d[DioSdiIdx];
      e.jtag.trst_n  = pad_in_m[MioTrstIdx];
      e.jtag.srst_n  = pad_in_m[MioSrstIdx];
    end
    // USB inputs toward the core in dp, dn, d, sense order
    e.dio_core_in = umux_in;
    if (use_uphy) begin
      usb_in = {rx.dp, rx.dn, rx.d, rx.sense};
    end else begin
      usb_in = {umux_in[DioUsbDpIdx], umux_in[DioUsbDnIdx],
                umux_in[DioUsbDIdx], umux_in[DioUsbSenseIdx]};
    end
    if (flip) begin
      usb_in = {usb_in[2], usb_in[3], ~usb_in[1], usb_in[0]};
    end
    e.dio_core_in[DioUsbDpIdx]    = usb_in[3];
    e.dio_core_in[DioUsbDnIdx]    = usb_in[2];
    e.dio_core_in[DioUsbDIdx]     = usb_in[1];
    e.dio_core_in[DioUsbSenseIdx] = usb_in[0];
    e.uphy_tx.dp       = umux.out[DioUsbDpIdx];
    e.uphy_tx.dn       = umux.out[DioUsbDnIdx];
    e.uphy_tx.oe_n     = ~umux.oe[DioUsbDpIdx];
    e.uphy_tx.dppullup = umux.out[DioUsbDpPullupIdx] & umux.oe[DioUsbDpPullupIdx];
    return e;
  endfunction

  function automatic shell_out_t expected_now();
    return shell_model(mio_pad_in, dio_pad_in, mio_core, dio_core, jtag_tdo, uphy_rx,
                       exp_jtag_en, exp_use_uphy);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Drive and check
  //////////////////////////////////////////////////////////////////////

  task automatic compare_field(input string name, input logic [63:0] exp_val,
                               input logic [63:0] act_val);
    check_cnt++;
    assert (act_val === exp_val) else begin
      $display("** Error: %s expected %h, got %h", name, exp_val, act_val);
      err_cnt++;
    end
  endtask

  task automatic check_model();
    shell_out_t e;
    e = expected_now();
    compare_field("mio_pad_o", e.mio_pad, mio_pad_o);
    compare_field("dio_pad_o", e.dio_pad, dio_pad_o);
    compare_field("mio_core_in_o", e.mio_core_in, mio_core_in_o);
    compare_field("dio_core_in_o", e.dio_core_in, dio_core_in_o);
    compare_field("jtag_o", e.jtag, jtag_o);
    compare_field("uphy_tx_o", e.uphy_tx, uphy_tx_o);
  endtask

  // Random vectors with the straps and the D- pullup oe forced
  task automatic drive_inputs(input logic jtag_strap, input logic phy_strap, input logic flip);
    logic [31:0] pads;
    logic [31:0] core;
    logic [31:0] misc;
    pads = $urandom;
    core = $urandom;
    misc = $urandom;
    pads[MioJtagEnIdx]  = jtag_strap;
    pads[MioUphySelIdx] = phy_strap;
    core[DioUsbDnPullupIdx] = flip;
    @(posedge clk);
    mio_pad_in <= pads;
    dio_pad_in <= misc[14:0];
    mio_core   <= {$urandom, $urandom};
    dio_core   <= core[29:0];
    jtag_tdo   <= misc[15];
    uphy_rx    <= misc[19:16];
    exp_jtag_en  = jtag_strap;
    exp_use_uphy = phy_strap;
  endtask

  // Outputs are sampled on the falling edge
  task automatic settle_straps();
    int   cycles;
    logic settled;
    cycles  = 0;
    settled = 1'b0;
    while (!settled && cycles < 10) begin
      @(posedge clk);
      @(negedge clk);
      cycles++;
      settled = (dut_out === expected_now());
    end
    assert (settled) else begin
      $display("Strap change did not settle within 10 clock cycles");
      err_cnt++;
    end
    if (settled) begin
      assert (cycles <= 2) else begin
        $display("Strap change took %0d clock cycles instead of 2", cycles);
        err_cnt++;
      end
    end
  endtask

  task automatic run_vector(input logic jtag_strap, input logic phy_strap, input logic flip);
    drive_inputs(jtag_strap, phy_strap, flip);
    settle_straps();
    check_model();
  endtask

  task automatic finish_test(input string name, input int errs_at_start);
    test_cnt++;
    if (err_cnt != errs_at_start) begin
      test_fail_cnt++;
    end
    $display("%s: done, %0d errors", name, err_cnt - errs_at_start);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_passthrough();
    int errs;
    errs = err_cnt;
    repeat (10) begin
      run_vector(1'b0, 1'b0, 1'b0);
      compare_field("mio_pad_o", mio_core, mio_pad_o);
      compare_field("dio_pad_o", dio_core, dio_pad_o);
      compare_field("mio_core_in_o", mio_pad_in, mio_core_in_o);
      compare_field("dio_core_in_o", dio_pad_in, dio_core_in_o);
      compare_field("jtag_o", 5'b00010, jtag_o);
    end
    finish_test("passthrough", errs);
  endtask

  task automatic test_jtag_overlay();
    int errs;
    errs = err_cnt;
    repeat (10) begin
      run_vector(1'b1, 1'b0, 1'b0);
      compare_field("dio_pad_o.out[sdo]", jtag_tdo, dio_pad_o.out[DioSdoIdx]);
      compare_field("dio_pad_o.oe[sdo]", 1'b1, dio_pad_o.oe[DioSdoIdx]);
      compare_field("dio_core_in_o[csb]", 1'b1, dio_core_in_o[DioCsbIdx]);
    end
    // Dropping the strap gives the pins back
    run_vector(1'b0, 1'b0, 1'b0);
    finish_test("jtag_overlay", errs);
  endtask

  task automatic test_usb_pinflip();
    int errs;
    errs = err_cnt;
    repeat (10) begin
      run_vector(1'b0, 1'b0, 1'b1);
      compare_field("dio_pad_o.out[dp]", dio_core.out[DioUsbDnIdx], dio_pad_o.out[DioUsbDpIdx]);
      compare_field("dio_core_in_o[d]", !dio_pad_in[DioUsbDIdx], dio_core_in_o[DioUsbDIdx]);
      run_vector(1'b0, 1'b0, 1'b0);
    end
    finish_test("usb_pinflip", errs);
  endtask

  task automatic test_phy_select();
    int errs;
    errs = err_cnt;
    repeat (10) begin
      run_vector(1'b0, 1'b1, 1'b0);
      compare_field("dio_core_in_o[sense]", uphy_rx.sense, dio_core_in_o[DioUsbSenseIdx]);
      run_vector(1'b0, 1'b1, 1'b1);
    end
    run_vector(1'b0, 1'b0, 1'b0);
    finish_test("phy_select", errs);
  endtask

  task automatic test_random_sweep();
    int          errs;
    logic [31:0] r;
    errs = err_cnt;
    repeat (200) begin
      r = $urandom;
      run_vector(r[0], r[1], r[2]);
    end
    finish_test("random_sweep", errs);
  endtask

  initial begin
    int cycles;
    void'($urandom(32'he737));
    err_cnt       = 0;
    check_cnt     = 0;
    test_cnt      = 0;
    test_fail_cnt = 0;
    exp_jtag_en   = 1'b0;
    exp_use_uphy  = 1'b0;
    mio_pad_in <= '0;
    dio_pad_in <= '0;
    mio_core   <= '0;
    dio_core   <= '0;
    jtag_tdo   <= 1'b0;
    uphy_rx    <= '0;
    cycles = 0;
    while (arst_n !== 1'b1 && cycles < 20) begin
      @(posedge clk);
      cycles++;
    end
    assert (arst_n === 1'b1) else begin
      $display("Reset was not released within 20 clock cycles");
      err_cnt++;
    end
    test_passthrough();
    test_jtag_overlay();
    test_usb_pinflip();
    test_phy_select();
    test_random_sweep();
    $display("Tests: %0d run, %0d with errors; checks: %0d, errors: %0d",
             test_cnt, test_fail_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule : board_io_shell_tb

/* verification/tb_clk_gen.sv */
//////////////////////////////////////////////////////////////////////
// Testbench clock and reset
// 100 ns clock, reset held low for the first 4 cycles
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  // Half period of 50 ns
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // Released on the falling edge after the 4th rising edge
  initial begin
    arst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule : tb_clk_gen
